// ==== source/fbuf_defs.svh ====
// Word width must hold a whole number of pixels and the FIFO must be at least twice the burst
`ifndef FBUF_DEFS_SVH
`define FBUF_DEFS_SVH

// Bus address width in words
`define FBUF_AW 24

// Bus data word width
`define FBUF_DW 32

// One video pixel
`define FBUF_PW 8

// Width of frame height, width and positions
`define FBUF_LGFRAME 11

// FIFO depth as log2, 32 words
`define FBUF_LGFIFO 5

// Longest burst as log2, 16 requests
`define FBUF_LGBURST 4

`endif

// ==== source/fbuf_pkg.sv ====
// Types follow the widths in the defines header and change only through it
`include "fbuf_defs.svh"

package fbuf_pkg;

	// Word address on the bus
	typedef logic [`FBUF_AW-1:0] wb_addr_t;

	// Data word as read from memory
	typedef logic [`FBUF_DW-1:0] wb_word_t;

	// Single pixel on the video stream
	typedef logic [`FBUF_PW-1:0] pixel_t;

	// Height, width or raster position
	typedef logic [`FBUF_LGFRAME-1:0] frame_dim_t;

	// FIFO level, one bit wider than the pointers
	typedef logic [`FBUF_LGFIFO:0] fifo_fill_t;

	// Word plus its raster markers
	typedef struct packed {
		logic     vlast;
		logic     hlast;
		wb_word_t word;
	} fifo_entry_t;

endpackage

// ==== source/fbuf_burst_fsm.sv ====
// Needs a pipelined slave that acks each accepted read once and in order and an err drops the burst
`timescale 1ns/100ps
`include "fbuf_defs.svh"

module fbuf_burst_fsm (
	input  logic                 i_clk,
	input  logic                 i_reset,
	input  fbuf_pkg::wb_addr_t   i_baseaddr,
	input  fbuf_pkg::fifo_fill_t i_fifo_fill,
	input  logic                 i_req_hlast,
	input  logic                 i_req_vlast,
	input  logic                 i_wb_stall,
	input  logic                 i_wb_ack,
	input  logic                 i_wb_err,
	output logic                 o_wb_cyc,
	output logic                 o_wb_stb,
	output fbuf_pkg::wb_addr_t   o_wb_addr
);
	typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_DRAIN} state_t;
	typedef logic [`FBUF_LGFIFO+1:0] commit_t;

	state_t                   state;
	logic [`FBUF_LGBURST-1:0] req_count;
	logic [`FBUF_LGBURST:0]   outstanding;
	logic                     reload;
	logic                     accept;
	logic                     last_req;
	commit_t                  committed;

	// Request taken by the slave
	assign accept = o_wb_stb && !i_wb_stall;

	// FIFO words in use or promised, counting this request
	assign committed = commit_t'(i_fifo_fill) + commit_t'(outstanding) + 1'b1;

	// Stop at the burst limit or when the FIFO would be fully spoken for
	assign last_req = (req_count == '1) || (committed >= commit_t'(1 << `FBUF_LGFIFO));

	////////////////////////////////////////
	// Bus control
	////////////////////////////////////////
	always_ff @(posedge i_clk or posedge i_reset)
	begin
		if (i_reset)
		begin
			state       <= ST_IDLE;
			o_wb_cyc    <= 1'b0;
			o_wb_stb    <= 1'b0;
			req_count   <= '0;
			outstanding <= '0;
			reload      <= 1'b1;
		end
		else if (o_wb_cyc && i_wb_err)
		begin
			// Abort, forget pending acks and restart the frame
			state       <= ST_IDLE;
			o_wb_cyc    <= 1'b0;
			o_wb_stb    <= 1'b0;
			outstanding <= '0;
			reload      <= 1'b1;
		end
		else
		begin
			if (accept)
				req_count <= req_count + 1'b1;
			case ({accept, i_wb_ack})
				2'b10: outstanding <= outstanding + 1'b1;
				2'b01: outstanding <= outstanding - 1'b1;
				default: outstanding <= outstanding;
			endcase

			case (state)
				ST_IDLE:
				begin
					// Enough room for a full burst
					if (i_fifo_fill[`FBUF_LGFIFO:`FBUF_LGBURST] == '0)
					begin
						state     <= ST_REQ;
						o_wb_cyc  <= 1'b1;
						o_wb_stb  <= 1'b1;
						req_count <= '0;
						reload    <= 1'b0;
					end
				end
				ST_REQ:
				begin
					if (accept && last_req)
					begin
						o_wb_stb <= 1'b0;
						state    <= ST_DRAIN;
					end
				end
				ST_DRAIN:
				begin
					// Last ack drops cyc on this edge
					if (i_wb_ack && outstanding == 1)
					begin
						o_wb_cyc <= 1'b0;
						state    <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// Address generation
	////////////////////////////////////////
	always_ff @(posedge i_clk)
	begin
		if (state == ST_IDLE && reload)
			o_wb_addr <= i_baseaddr;
		else if (accept)
		begin
			// Lines are back to back, so only the frame end jumps
			if (i_req_hlast && i_req_vlast)
				o_wb_addr <= i_baseaddr;
			else
				o_wb_addr <= o_wb_addr + 1'b1;
		end
	end

endmodule

// ==== source/fbuf_raster_counter.sv ====
// Width and height must be at least 2 and restart wins over step
`timescale 1ns/100ps

module fbuf_raster_counter (
	input  logic                 i_clk,
	input  logic                 i_reset,
	input  logic                 i_restart,
	input  logic                 i_step,
	input  fbuf_pkg::frame_dim_t i_width,
	input  fbuf_pkg::frame_dim_t i_height,
	output logic                 o_hlast,
	output logic                 o_vlast
);
	import fbuf_pkg::*;

	localparam int DIM_W = $bits(frame_dim_t);

	frame_dim_t   hpos;
	frame_dim_t   vpos;
	logic [DIM_W:0] h_ahead;
	logic [DIM_W:0] v_ahead;

	// Two ahead of now, one extra bit so the top does not wrap
	assign h_ahead = {1'b0, hpos} + 2'd2;
	assign v_ahead = {1'b0, vpos} + 2'd2;

	always_ff @(posedge i_clk or posedge i_reset)
	begin
		if (i_reset)
		begin
			hpos    <= '0;
			vpos    <= '0;
			o_hlast <= 1'b0;
			o_vlast <= 1'b0;
		end
		else if (i_restart)
		begin
			hpos    <= '0;
			vpos    <= '0;
			o_hlast <= 1'b0;
			o_vlast <= 1'b0;
		end
		else if (i_step)
		begin
			hpos    <= hpos + 1'b1;
			// Flag set while stepping onto the last column
			o_hlast <= (h_ahead >= {1'b0, i_width});
			if (o_hlast)
			begin
				hpos    <= '0;
				o_hlast <= 1'b0;
				vpos    <= vpos + 1'b1;
				o_vlast <= (v_ahead >= {1'b0, i_height});
				if (o_vlast)
				begin
					// End of frame
					vpos    <= '0;
					o_vlast <= 1'b0;
				end
			end
		end
	end

endmodule

// ==== source/fbuf_word_fifo.sv ====
// Show-ahead FIFO where a write to a full FIFO is dropped and a read when empty is ignored
`timescale 1ns/100ps
`include "fbuf_defs.svh"

module fbuf_word_fifo (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_wr,
	input  fbuf_pkg::fifo_entry_t i_entry,
	input  logic                  i_rd,
	output fbuf_pkg::fifo_entry_t o_entry,
	output logic                  o_empty,
	output fbuf_pkg::fifo_fill_t  o_fill
);
	import fbuf_pkg::*;

	localparam int DEPTH = 1 << `FBUF_LGFIFO;

	fifo_entry_t             mem [DEPTH];
	logic [`FBUF_LGFIFO-1:0] wr_ptr;
	logic [`FBUF_LGFIFO-1:0] rd_ptr;
	logic                    full;
	logic                    do_wr;
	logic                    do_rd;

	// Top bit of fill only set at exactly DEPTH
	assign full    = o_fill[`FBUF_LGFIFO];
	assign o_empty = (o_fill == '0);
	assign do_wr   = i_wr && !full;
	assign do_rd   = i_rd && !o_empty;

	// Head of queue, valid whenever not empty
	assign o_entry = mem[rd_ptr];

	always_ff @(posedge i_clk)
	begin
		if (do_wr)
			mem[wr_ptr] <= i_entry;
	end

	always_ff @(posedge i_clk or posedge i_reset)
	begin
		if (i_reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			o_fill <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: o_fill <= o_fill + 1'b1;
				2'b01: o_fill <= o_fill - 1'b1;
				default: o_fill <= o_fill;
			endcase
		end
	end

endmodule

// ==== source/fbuf_pixel_unpacker.sv ====
// Word width must be a whole multiple of the pixel width and pixels leave most significant first
`timescale 1ns/100ps
`include "fbuf_defs.svh"

module fbuf_pixel_unpacker (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  fbuf_pkg::fifo_entry_t i_entry,
	input  logic                  i_empty,
	output logic                  o_rd,
	output logic                  o_vid_valid,
	input  logic                  i_vid_ready,
	output fbuf_pkg::pixel_t      o_vid_data,
	output logic                  o_vid_last,
	output logic                  o_vid_sof
);
	import fbuf_pkg::*;

	localparam int DW    = `FBUF_DW;
	localparam int PW    = `FBUF_PW;
	localparam int NPIX  = DW / PW;
	localparam int CNT_W = $clog2(NPIX + 1);

	wb_word_t         sreg;
	logic [CNT_W-1:0] count;
	logic             word_hlast;
	logic             word_vlast;
	logic             xfer;
	logic             need_word;

	assign xfer = o_vid_valid && i_vid_ready;

	// Refill when idle or as the last pixel of a word goes out
	assign need_word = !o_vid_valid || (xfer && count == 1);
	assign o_rd      = need_word && !i_empty;

	// Current pixel sits in the top byte
	assign o_vid_data = sreg[DW-1 -: PW];

	////////////////////////////////////////
	// Stream control
	////////////////////////////////////////
	always_ff @(posedge i_clk or posedge i_reset)
	begin
		if (i_reset)
		begin
			o_vid_valid <= 1'b0;
			o_vid_last  <= 1'b0;
			// First pixel after reset starts a frame
			o_vid_sof   <= 1'b1;
			count       <= '0;
		end
		else
		begin
			// Next pixel opens a frame if this one closed it
			if (xfer)
				o_vid_sof <= o_vid_last && word_vlast;
			if (o_rd)
			begin
				o_vid_valid <= 1'b1;
				count       <= CNT_W'(NPIX);
				// Line end only ever on the last pixel of a word
				o_vid_last  <= 1'b0;
			end
			else if (xfer)
			begin
				count       <= count - 1'b1;
				o_vid_valid <= (count != 1);
				o_vid_last  <= word_hlast && (count == 2);
			end
		end
	end

	////////////////////////////////////////
	// Word shifter
	////////////////////////////////////////
	always_ff @(posedge i_clk)
	begin
		if (o_rd)
		begin
			sreg       <= i_entry.word;
			word_hlast <= i_entry.hlast;
			word_vlast <= i_entry.vlast;
		end
		else if (xfer)
			sreg <= sreg << PW;
	end

endmodule

// ==== source/fbuf_reader.sv ====
// Base, width and height must stay fixed while running and the frame must fit below the top address
`timescale 1ns/100ps

module fbuf_reader (
	input  logic                 i_clk,
	input  logic                 i_reset,
	input  fbuf_pkg::wb_addr_t   i_baseaddr,
	input  fbuf_pkg::frame_dim_t i_width,
	input  fbuf_pkg::frame_dim_t i_height,
	output logic                 o_wb_cyc,
	output logic                 o_wb_stb,
	output fbuf_pkg::wb_addr_t   o_wb_addr,
	input  logic                 i_wb_stall,
	input  logic                 i_wb_ack,
	input  fbuf_pkg::wb_word_t   i_wb_data,
	input  logic                 i_wb_err,
	output logic                 o_vid_valid,
	input  logic                 i_vid_ready,
	output fbuf_pkg::pixel_t     o_vid_data,
	output logic                 o_vid_last,
	output logic                 o_vid_sof
);
	import fbuf_pkg::*;

	logic        req_hlast;
	logic        req_vlast;
	logic        rx_hlast;
	logic        rx_vlast;
	logic        bus_err;
	logic        req_accept;
	fifo_entry_t wr_entry;
	fifo_entry_t rd_entry;
	fifo_fill_t  fifo_fill;
	logic        fifo_empty;
	logic        fifo_rd;

	// Error only counts inside a bus cycle
	assign bus_err    = o_wb_cyc && i_wb_err;
	assign req_accept = o_wb_stb && !i_wb_stall;

	// Tag each returned word with where it lands in the frame
	assign wr_entry = '{vlast: rx_vlast, hlast: rx_hlast, word: i_wb_data};

	////////////////////////////////////////
	// Request side
	////////////////////////////////////////
	fbuf_burst_fsm u_burst (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_baseaddr(i_baseaddr), .i_fifo_fill(fifo_fill),
		.i_req_hlast(req_hlast), .i_req_vlast(req_vlast),
		.i_wb_stall(i_wb_stall), .i_wb_ack(i_wb_ack), .i_wb_err(i_wb_err),
		.o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_addr(o_wb_addr)
	);

	fbuf_raster_counter u_req_pos (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_restart(bus_err), .i_step(req_accept),
		.i_width(i_width), .i_height(i_height),
		.o_hlast(req_hlast), .o_vlast(req_vlast)
	);

	////////////////////////////////////////
	// Receive side and output
	////////////////////////////////////////
	fbuf_raster_counter u_rx_pos (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_restart(bus_err), .i_step(i_wb_ack),
		.i_width(i_width), .i_height(i_height),
		.o_hlast(rx_hlast), .o_vlast(rx_vlast)
	);

	// Room is reserved before each request, so every ack fits
	fbuf_word_fifo u_fifo (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_wr(i_wb_ack), .i_entry(wr_entry),
		.i_rd(fifo_rd), .o_entry(rd_entry),
		.o_empty(fifo_empty), .o_fill(fifo_fill)
	);

	fbuf_pixel_unpacker u_unpack (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_entry(rd_entry), .i_empty(fifo_empty), .o_rd(fifo_rd),
		.o_vid_valid(o_vid_valid), .i_vid_ready(i_vid_ready),
		.o_vid_data(o_vid_data), .o_vid_last(o_vid_last), .o_vid_sof(o_vid_sof)
	);

endmodule

// ==== verification/fbuf_reader_sva.sv ====
// Counts outstanding reads from the bus itself and treats an err inside a cycle as clearing them
`timescale 1ns/100ps

module fbuf_reader_sva (
	input logic               i_clk,
	input logic               i_reset,
	input logic               o_wb_cyc,
	input logic               o_wb_stb,
	input fbuf_pkg::wb_addr_t o_wb_addr,
	input logic               i_wb_stall,
	input logic               i_wb_ack,
	input logic               i_wb_err,
	input logic               o_vid_valid,
	input logic               i_vid_ready,
	input fbuf_pkg::pixel_t   o_vid_data,
	input logic               o_vid_last,
	input logic               o_vid_sof
);
	logic [5:0] pending;

	// Requests still owed an ack
	always_ff @(posedge i_clk or posedge i_reset)
	begin
		if (i_reset)
			pending <= '0;
		else if (o_wb_cyc && i_wb_err)
			pending <= '0;
		else
			pending <= pending + 6'(o_wb_stb && !i_wb_stall) - 6'(i_wb_ack);
	end

	////////////////////////////////////////
	// Wishbone rules
	////////////////////////////////////////
	stb_in_cyc: assert property (@(posedge i_clk) disable iff (i_reset)
		o_wb_stb |-> o_wb_cyc)
		else $error("stb high outside a bus cycle");

	ack_owed: assert property (@(posedge i_clk) disable iff (i_reset)
		i_wb_ack |-> pending != '0)
		else $error("ack with no request outstanding");

	// Stalled request keeps its address
	addr_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		o_wb_stb && i_wb_stall |=> $stable(o_wb_addr))
		else $error("address moved while stalled");

	////////////////////////////////////////
	// Video stream rule
	////////////////////////////////////////
	stream_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		o_vid_valid && !i_vid_ready |=> o_vid_valid && $stable(o_vid_data)
			&& $stable(o_vid_last) && $stable(o_vid_sof))
		else $error("stream changed while waiting for ready");

endmodule

bind fbuf_reader fbuf_reader_sva u_sva (
	.i_clk(i_clk), .i_reset(i_reset),
	.o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_addr(o_wb_addr),
	.i_wb_stall(i_wb_stall), .i_wb_ack(i_wb_ack), .i_wb_err(i_wb_err),
	.o_vid_valid(o_vid_valid), .i_vid_ready(i_vid_ready),
	.o_vid_data(o_vid_data), .o_vid_last(o_vid_last), .o_vid_sof(o_vid_sof)
);

// ==== verification/fbuf_reader_tb.sv ====
// Memory model acks in order within three cycles, drops pending acks on an injected err, no writes
`timescale 1ns/100ps

module fbuf_reader_tb;
	import fbuf_pkg::*;

	localparam int TIMEOUT    = 20000;
	localparam int PIX_WORD   = 4;
	localparam int W_PIXELS   = 0;
	localparam int W_REQUESTS = 1;
	localparam int W_ERR      = 2;
	localparam int W_CYC_LOW  = 3;

	// DUT inputs with their start values
	logic       i_clk       = 1'b0;
	logic       i_reset     = 1'b1;
	wb_addr_t   i_baseaddr  = '0;
	frame_dim_t i_width     = frame_dim_t'(4);
	frame_dim_t i_height    = frame_dim_t'(3);
	logic       i_wb_stall  = 1'b0;
	logic       i_wb_ack    = 1'b0;
	wb_word_t   i_wb_data   = '0;
	logic       i_wb_err    = 1'b0;
	logic       i_vid_ready = 1'b0;

	logic     o_wb_cyc;
	logic     o_wb_stb;
	wb_addr_t o_wb_addr;
	logic     o_vid_valid;
	pixel_t   o_vid_data;
	logic     o_vid_last;
	logic     o_vid_sof;

	// Traffic shaping and logs
	logic [15:0] lfsr_state  = 16'd6846;
	logic        rand_stall  = 1'b0;
	logic        rand_ready  = 1'b0;
	logic        ready_level = 1'b1;
	logic        inject_err  = 1'b0;
	int          cycle       = 0;
	int          burst_reqs  = 0;
	int          max_burst   = 0;
	int          error_count = 0;
	int          tests_run   = 0;
	int          tests_failed = 0;
	wb_addr_t    cur_base;
	int          cur_width;
	int          cur_height;
	wb_addr_t    accept_log [$];
	wb_addr_t    ack_addr [$];
	int          ack_due [$];
	logic [9:0]  pix_log [$];

	fbuf_reader i_fbuf_reader (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_baseaddr(i_baseaddr), .i_width(i_width), .i_height(i_height),
		.o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_addr(o_wb_addr),
		.i_wb_stall(i_wb_stall), .i_wb_ack(i_wb_ack), .i_wb_data(i_wb_data),
		.i_wb_err(i_wb_err),
		.o_vid_valid(o_vid_valid), .i_vid_ready(i_vid_ready),
		.o_vid_data(o_vid_data), .o_vid_last(o_vid_last), .o_vid_sof(o_vid_sof)
	);

	always #2 i_clk = ~i_clk;

	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic rand_bit();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	// Memory contents depend on every address bit
	function automatic wb_word_t word_at(input wb_addr_t addr);
		return ({8'h00, addr} * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
	endfunction

	// Pixel k of the stream with the top byte of each word first
	function automatic pixel_t expected_pixel(input int k);
		int       word_idx;
		wb_word_t word;
		word_idx = (k / PIX_WORD) % (cur_width * cur_height);
		word     = word_at(cur_base + wb_addr_t'(word_idx));
		return pixel_t'(word >> (8 * (PIX_WORD - 1 - k % PIX_WORD)));
	endfunction

	////////////////////////////////////////
	// Wishbone slave and handshake drivers
	////////////////////////////////////////
	always @(posedge i_clk)
	begin
		int delay;
		int due;
		cycle = cycle + 1;
		i_wb_stall  <= rand_stall ? rand_bit() : 1'b0;
		i_vid_ready <= rand_ready ? rand_bit() : ready_level;
		if (i_reset || i_wb_err)
		begin
			// Pending reads die with reset or err
			ack_addr.delete();
			ack_due.delete();
			burst_reqs = 0;
			i_wb_ack <= 1'b0;
			i_wb_err <= 1'b0;
		end
		else
		begin
			// Requests are counted per bus cycle
			if (!o_wb_cyc)
				burst_reqs = 0;
			if (o_wb_stb && !i_wb_stall)
			begin
				accept_log.push_back(o_wb_addr);
				delay = 1 + int'({rand_bit(), rand_bit()}) % 3;
				due   = cycle + delay - 1;
				// Keep acks in order at one per cycle
				if (ack_due.size() > 0 && due <= ack_due[$])
					due = ack_due[$] + 1;
				ack_addr.push_back(o_wb_addr);
				ack_due.push_back(due);
				burst_reqs = burst_reqs + 1;
			end
			if (burst_reqs > max_burst)
				max_burst = burst_reqs;
			if (inject_err && o_wb_cyc && o_wb_stb)
			begin
				inject_err = 1'b0;
				ack_addr.delete();
				ack_due.delete();
				i_wb_ack <= 1'b0;
				i_wb_err <= 1'b1;
			end
			else if (ack_due.size() > 0 && ack_due[0] <= cycle)
			begin
				i_wb_ack  <= 1'b1;
				i_wb_data <= word_at(ack_addr.pop_front());
				void'(ack_due.pop_front());
			end
			else
				i_wb_ack <= 1'b0;
		end
	end

	// Stream monitor logs {sof, last, data}
	always @(posedge i_clk)
	begin
		if (!i_reset && o_vid_valid && i_vid_ready)
			pix_log.push_back({o_vid_sof, o_vid_last, o_vid_data});
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////
	task automatic report_value(input string sig, input int idx, input logic [31:0] got,
		input logic [31:0] exp);
		$display("** Error: %s [%0d] got 0x%h expected 0x%h", sig, idx, got, exp);
		error_count = error_count + 1;
	endtask

	function automatic bit reached(input int what, input int n);
		case (what)
			W_PIXELS:   return pix_log.size() >= n;
			W_REQUESTS: return accept_log.size() >= n;
			W_ERR:      return i_wb_err;
			default:    return !o_wb_cyc;
		endcase
	endfunction

	// Polls on the falling edge where outputs are settled
	task automatic wait_until(input int what, input int n, input string label);
		int t;
		t = 0;
		while (!reached(what, n) && t < TIMEOUT)
		begin
			@(negedge i_clk);
			t = t + 1;
		end
		if (!reached(what, n))
		begin
			$display("Timeout while waiting for %s", label);
			$display("=== FAIL ===");
			$finish;
		end
	endtask

	task automatic set_traffic(input logic stall_rand, input logic ready_rand,
		input logic ready_lvl);
		rand_stall  = stall_rand;
		rand_ready  = ready_rand;
		ready_level = ready_lvl;
	endtask

	// Frame setup held under reset for 10 cycles
	task automatic apply_reset(input wb_addr_t base, input int width, input int height);
		cur_base   = base;
		cur_width  = width;
		cur_height = height;
		@(posedge i_clk);
		i_reset    <= 1'b1;
		i_baseaddr <= base;
		i_width    <= frame_dim_t'(width);
		i_height   <= frame_dim_t'(height);
		@(negedge i_clk);
		accept_log.delete();
		pix_log.delete();
		max_burst = 0;
		repeat (10) @(posedge i_clk);
		i_reset <= 1'b0;
	endtask

	task automatic check_stream(input int n, input bit marks);
		int         k;
		int         line_px;
		int         frame_px;
		logic [9:0] got;
		line_px  = PIX_WORD * cur_width;
		frame_px = line_px * cur_height;
		for (k = 0; k < n; k++)
		begin
			got = pix_log[k];
			if (got[7:0] !== expected_pixel(k))
				report_value("o_vid_data", k, got[7:0], expected_pixel(k));
			if (marks && got[8] !== (k % line_px == line_px - 1))
				report_value("o_vid_last", k, got[8], (k % line_px == line_px - 1));
			if (marks && got[9] !== (k % frame_px == 0))
				report_value("o_vid_sof", k, got[9], (k % frame_px == 0));
		end
	endtask

	task automatic finish_test(input string name, input int start);
		tests_run = tests_run + 1;
		if (error_count > start)
		begin
			tests_failed = tests_failed + 1;
			$display("%s: failed with %0d errors", name, error_count - start);
		end
		else
			$display("%s: passed", name);
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////
	task automatic test_reset_state();
		int start;
		start = error_count;
		set_traffic(1'b0, 1'b0, 1'b1);
		apply_reset(24'h12_3400, 4, 3);
		@(negedge i_clk);
		if (o_wb_cyc !== 1'b0)
			report_value("o_wb_cyc", 0, o_wb_cyc, 0);
		if (o_wb_stb !== 1'b0)
			report_value("o_wb_stb", 0, o_wb_stb, 0);
		if (o_vid_valid !== 1'b0)
			report_value("o_vid_valid", 0, o_vid_valid, 0);
		wait_until(W_REQUESTS, 1, "first bus request");
		if (accept_log[0] !== cur_base)
			report_value("o_wb_addr", 0, accept_log[0], cur_base);
		finish_test("Reset state", start);
	endtask

	task automatic test_pixel_order();
		int start;
		start = error_count;
		set_traffic(1'b0, 1'b0, 1'b1);
		apply_reset(24'h00_0100, 4, 3);
		wait_until(W_PIXELS, 48, "one frame of pixels");
		check_stream(48, 1'b0);
		finish_test("Pixel order", start);
	endtask

	// Continues the frame stream of the order test
	task automatic test_markers();
		int start;
		int i;
		start = error_count;
		wait_until(W_PIXELS, 96, "two frames of pixels");
		wait_until(W_REQUESTS, 24, "two frames of requests");
		check_stream(96, 1'b1);
		for (i = 0; i < 24; i++)
		begin
			if (accept_log[i] !== cur_base + wb_addr_t'(i % 12))
				report_value("o_wb_addr", i, accept_log[i], cur_base + wb_addr_t'(i % 12));
		end
		finish_test("Line and frame markers", start);
	endtask

	task automatic test_backpressure();
		int start;
		start = error_count;
		set_traffic(1'b1, 1'b1, 1'b1);
		apply_reset(24'hab_cd10, 6, 4);
		wait_until(W_PIXELS, 192, "two frames under back-pressure");
		check_stream(192, 1'b1);
		finish_test("Back-pressure and stalls", start);
	endtask

	task automatic test_burst_bound();
		int start;
		start = error_count;
		// Stream blocked so the FIFO fills
		set_traffic(1'b1, 1'b0, 1'b0);
		apply_reset(24'h7f_fff0, 8, 4);
		wait_until(W_REQUESTS, 24, "requests with the stream blocked");
		wait_until(W_CYC_LOW, 0, "bus cycle to end on a full FIFO");
		set_traffic(1'b1, 1'b1, 1'b1);
		wait_until(W_PIXELS, 256, "two frames after release");
		check_stream(256, 1'b1);
		if (max_burst > 16)
		begin
			$display("Requests within one bus cycle reached %0d, above the burst of 16",
				max_burst);
			error_count = error_count + 1;
		end
		finish_test("Burst bound", start);
	endtask

	task automatic test_bus_error();
		int start;
		int err_index;
		start = error_count;
		set_traffic(1'b0, 1'b0, 1'b1);
		apply_reset(24'h00_3f00, 4, 3);
		wait_until(W_REQUESTS, 5, "requests before the error");
		inject_err = 1'b1;
		wait_until(W_ERR, 0, "injected bus error");
		err_index = accept_log.size();
		@(negedge i_clk);
		if (o_wb_cyc !== 1'b0)
			report_value("o_wb_cyc", err_index, o_wb_cyc, 0);
		wait_until(W_REQUESTS, err_index + 1, "request after the error");
		if (accept_log[err_index] !== cur_base)
			report_value("o_wb_addr", err_index, accept_log[err_index], cur_base);
		finish_test("Bus error", start);
	endtask

	initial
	begin
		test_reset_state();
		test_pixel_order();
		test_markers();
		test_backpressure();
		test_burst_bound();
		test_bus_error();
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
		if (error_count == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+source
source/fbuf_pkg.sv
source/fbuf_burst_fsm.sv
source/fbuf_raster_counter.sv
source/fbuf_word_fifo.sv
source/fbuf_pixel_unpacker.sv
source/fbuf_reader.sv
verification/fbuf_reader_sva.sv
verification/fbuf_reader_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the framebuffer reader testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module fbuf_reader_tb -o sim_fbuf_reader > "$BUILD_LOG" 2>&1
status=$?
cat "$BUILD_LOG"
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_fbuf_reader > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "=== FAIL ===" "$SIM_LOG"; then
	exit 1
fi
exit 0
